/* src/code_bank.sv */
// reading a row in the same cycle it is written returns stale data
`timescale 1ns/1ps
`default_nettype none

`include "prefetch_config.svh"

module code_bank (
    input  wire logic                     clk,
    input  wire logic                     we,         // load port
    input  wire prefetch_pkg::bank_addr_t waddr,
    input  wire logic [7:0]               wdata,
    input  wire logic                     rd_en,
    input  wire prefetch_pkg::bank_addr_t rd_addr,
    output logic [7:0]                    rd_data     // valid the cycle after rd_en
);

    logic [7:0] mem [`PF_BANK_DEPTH];   // one byte per row

    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
    end

    // registered read, holds its value while idle
    always_ff @(posedge clk) begin
        if (rd_en)
            rd_data <= mem[rd_addr];
    end

    // loading and fetching of one row must not overlap
    a_no_rw_clash: assert property (@(posedge clk)
        (we && rd_en) |-> (waddr != rd_addr))
        else $error("code_bank: write and read of row %0d in one cycle", waddr);

endmodule

`default_nettype wire

/* src/code_fetch.sv */
// one read in flight at a time, so the best rate is one bank row every two cycles
`timescale 1ns/1ps
`default_nettype none

`include "prefetch_config.svh"

module code_fetch (
    input  wire logic                     clk,
    input  wire logic                     pr_reset,
    input  wire logic                     flush,
    input  wire prefetch_pkg::linear_t    prefetch_address,
    input  wire prefetch_pkg::fetch_len_t prefetch_length,
    input  wire logic                     space_ok,          // fifo can take a full row
    output logic [`PF_BANKS-1:0]          rd_en,
    output logic [`PF_BANKS*$bits(prefetch_pkg::bank_addr_t)-1:0] rd_addr,
    output logic                          prefetched_do,
    output prefetch_pkg::fetch_len_t      prefetched_length,
    output logic [$clog2(`PF_BANKS)-1:0]  rd_offset
);
    import prefetch_pkg::*;

    localparam int OFS_W = $clog2(`PF_BANKS);
    localparam int ROW_W = $bits(bank_addr_t);

    logic [OFS_W-1:0] offset;       // first bank of this read
    bank_addr_t       row;
    fetch_len_t       to_end;       // bytes up to the next row boundary
    fetch_len_t       issue_len;
    logic             issue;

    logic             inflight;     // banks answer next cycle
    fetch_len_t       inflight_len;
    logic [OFS_W-1:0] inflight_ofs;

    assign offset    = prefetch_address[OFS_W-1:0];
    assign row       = prefetch_address[OFS_W +: ROW_W];   // upper bits alias
    assign to_end    = fetch_len_t'(`PF_BANKS) - fetch_len_t'(offset);
    assign issue_len = (prefetch_length < to_end) ? prefetch_length : to_end;

    // no new read while flushing since the address is about to change
    assign issue = !inflight && (prefetch_length != '0) && space_ok && !flush;

    always_comb begin
        for (int i = 0; i < `PF_BANKS; i++) begin
            rd_en[i] = issue;
            // banks below the offset point at the following row
            rd_addr[i*ROW_W +: ROW_W] = (i < int'(offset)) ? bank_addr_t'(row + 1'b1) : row;
        end
    end

    always_ff @(posedge clk) begin
        if (pr_reset)
            inflight <= 1'b0;
        else
            inflight <= issue;      // clears itself the cycle after
    end

    // captured at issue and reported with the completion
    always_ff @(posedge clk) begin
        if (issue) begin
            inflight_len <= issue_len;
            inflight_ofs <= offset;
        end
    end

    assign prefetched_do     = inflight && !flush;  // flush drops the returning data
    assign prefetched_length = inflight_len;
    assign rd_offset         = inflight_ofs;

    // prefetch only moves on a completion, so its request holds under a read
    a_req_stable: assert property (@(posedge clk) disable iff (pr_reset)
        inflight |-> ($stable(prefetch_address) && $stable(prefetch_length)))
        else $error("code_fetch: fetch request changed while a read is in flight");

endmodule

`default_nettype wire

/* src/code_prefetch_top.sv */
// load memory only while no fetch is running, the write port bypasses the fetch path
`timescale 1ns/1ps
`default_nettype none

`include "prefetch_config.svh"

module code_prefetch_top (
    input  wire logic                  clk,
    input  wire logic                  pr_reset,
    input  wire logic                  flush,
    input  wire prefetch_pkg::linear_t prefetch_eip,
    input  wire logic [63:0]           cs_cache,
    input  wire logic                  mem_we,
    input  wire logic [$clog2(`PF_BANKS*`PF_BANK_DEPTH)-1:0] mem_waddr,  // byte address
    input  wire logic [7:0]            mem_wdata,
    input  wire logic                  code_accept,
    output logic                       code_valid,
    output logic [7:0]                 code_byte,
    output logic                       code_limit
);
    import prefetch_pkg::*;

    localparam int OFS_W = $clog2(`PF_BANKS);
    localparam int ROW_W = $bits(bank_addr_t);

    linear_t                    prefetch_address;
    fetch_len_t                 prefetch_length;
    logic                       limit_signal;
    logic                       prefetched_do;
    fetch_len_t                 prefetched_length;
    logic [OFS_W-1:0]           rd_offset;
    logic                       space_ok;
    logic [`PF_BANKS-1:0]       rd_en;
    logic [`PF_BANKS*ROW_W-1:0] rd_addr;     // one row per bank
    logic [`PF_BANKS*8-1:0]     bank_data;   // bank outputs by index
    bank_addr_t                 mem_row;

    assign mem_row = mem_waddr[OFS_W +: ROW_W];  // low bits pick the bank

    prefetch u_prefetch (
        .clk, .pr_reset, .flush, .prefetch_eip, .cs_cache,
        .prefetched_do, .prefetched_length,
        .prefetch_address, .prefetch_length, .limit_signal
    );

    code_fetch u_code_fetch (
        .clk, .pr_reset, .flush, .prefetch_address, .prefetch_length, .space_ok,
        .rd_en, .rd_addr, .prefetched_do, .prefetched_length, .rd_offset
    );

    for (genvar i = 0; i < `PF_BANKS; i++) begin : g_bank
        code_bank u_bank (
            .clk,
            .we      (mem_we && (mem_waddr[OFS_W-1:0] == OFS_W'(i))),
            .waddr   (mem_row),
            .wdata   (mem_wdata),
            .rd_en   (rd_en[i]),
            .rd_addr (rd_addr[i*ROW_W +: ROW_W]),
            .rd_data (bank_data[i*8 +: 8])
        );
    end

    prefetch_fifo u_prefetch_fifo (
        .clk, .pr_reset, .flush, .prefetched_do, .prefetched_length, .rd_offset,
        .bank_data, .limit_signal, .code_accept,
        .space_ok, .code_valid, .code_byte, .code_limit
    );

endmodule

`default_nettype wire

/* src/prefetch.sv */
// a limit of 0xffffffff with eip 0 wraps the byte count to zero, no type or present checks
`timescale 1ns/1ps
`default_nettype none

`include "prefetch_config.svh"

module prefetch (
    input  wire logic                   clk,
    input  wire logic                   pr_reset,
    input  wire logic                   flush,              // one-cycle reload strobe
    input  wire prefetch_pkg::linear_t  prefetch_eip,
    input  wire logic [63:0]            cs_cache,           // cached cs descriptor
    input  wire logic                   prefetched_do,      // fetch completed this cycle
    input  wire prefetch_pkg::fetch_len_t prefetched_length,
    output prefetch_pkg::linear_t       prefetch_address,
    output prefetch_pkg::fetch_len_t    prefetch_length,
    output logic                        limit_signal
);
    import prefetch_pkg::*;

    linear_t linear;            // next byte to fetch
    limit_t  limit;             // bytes left below the segment limit
    logic    limit_signaled;    // limit pulse already sent since last reload

    linear_t cs_base;
    limit_t  cs_limit;

    // base is split across the descriptor
    assign cs_base = {cs_cache[63:56], cs_cache[39:16]};

    // 20-bit limit, scaled to pages when g is set
    assign cs_limit = cs_cache[DESC_BIT_G] ? {cs_cache[51:48], cs_cache[15:0], 12'hfff}
                                           : {12'd0, cs_cache[51:48], cs_cache[15:0]};

    assign prefetch_address = linear;

    // never ask for more than one bank row
    assign prefetch_length = (limit > limit_t'(`PF_BANKS)) ? fetch_len_t'(`PF_BANKS)
                                                           : fetch_len_t'(limit);

    // first cycle with nothing left
    assign limit_signal = (limit == '0) && !limit_signaled;

    always_ff @(posedge clk) begin
        if (pr_reset) begin
            linear         <= `PF_STARTUP_LINEAR;
            limit          <= `PF_STARTUP_LIMIT;
            limit_signaled <= 1'b0;
        end else if (flush) begin
            linear         <= cs_base + prefetch_eip;
            // eip past the limit leaves nothing to fetch
            limit          <= (cs_limit >= prefetch_eip) ? cs_limit - prefetch_eip + 32'd1
                                                         : '0;
            limit_signaled <= 1'b0;                     // rearm the pulse
        end else begin
            if (prefetched_do) begin
                linear <= linear + linear_t'(prefetched_length);
                limit  <= limit - limit_t'(prefetched_length);
            end
            if (limit_signal)
                limit_signaled <= 1'b1;                 // one pulse per reload
        end
    end

    // code_fetch clips every read to prefetch_length, so a completion fits the limit
    a_len_in_limit: assert property (@(posedge clk) disable iff (pr_reset)
        prefetched_do |-> (limit >= limit_t'(prefetched_length)))
        else $error("prefetch: completed length %0d beyond limit %0d",
                    prefetched_length, limit);

endmodule

`default_nettype wire

/* src/prefetch_config.svh */
// bank count must stay a power of two and the fifo must hold at least two full bank reads
`ifndef PREFETCH_CONFIG_SVH
`define PREFETCH_CONFIG_SVH

// byte banks in the code memory
// also the widest single fetch in bytes
`define PF_BANKS 4

// rows per bank
// 4 banks of 256 rows give 1 KB, higher linear addresses alias
`define PF_BANK_DEPTH 256

// byte entries in the prefetch queue
`define PF_FIFO_DEPTH 8

// linear address after reset
`define PF_STARTUP_LINEAR 32'd0

// bytes left in the segment after reset
// zero keeps the fetcher idle until the first flush
`define PF_STARTUP_LIMIT 32'd0

`endif

/* src/prefetch_fifo.sv */
// depth must be a power of two and hold at least PF_BANKS bytes
`timescale 1ns/1ps
`default_nettype none

`include "prefetch_config.svh"

module prefetch_fifo (
    input  wire logic                     clk,
    input  wire logic                     pr_reset,
    input  wire logic                     flush,          // drops queued bytes
    input  wire logic                     prefetched_do,
    input  wire prefetch_pkg::fetch_len_t prefetched_length,
    input  wire logic [$clog2(`PF_BANKS)-1:0] rd_offset,  // bank holding the first byte
    input  wire logic [`PF_BANKS*8-1:0]   bank_data,      // bank outputs by index
    input  wire logic                     limit_signal,
    input  wire logic                     code_accept,
    output logic                          space_ok,
    output logic                          code_valid,
    output logic [7:0]                    code_byte,
    output logic                          code_limit
);

    localparam int PTR_W = $clog2(`PF_FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;
    localparam int OFS_W = $clog2(`PF_BANKS);

    logic [7:0]       mem [`PF_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;        // bytes queued
    logic [CNT_W-1:0] push_len;
    logic             pop;
    logic             limit_flag;   // sticky until flush
    logic [7:0]       ordered [`PF_BANKS];

    // program order starts at bank rd_offset and wraps
    always_comb begin
        for (int j = 0; j < `PF_BANKS; j++) begin
            ordered[j] = bank_data[8 * int'(OFS_W'(rd_offset + j)) +: 8];
        end
    end

    assign push_len   = prefetched_do ? CNT_W'(prefetched_length) : '0;
    assign code_valid = (count != '0);
    assign code_byte  = mem[rd_ptr];
    assign pop        = code_accept && code_valid;
    assign space_ok   = (CNT_W'(`PF_FIFO_DEPTH) - count) >= CNT_W'(`PF_BANKS);  // room for a row
    assign code_limit = limit_flag && (count == '0);  // only once the queue has drained

    always_ff @(posedge clk) begin
        if (pr_reset || flush) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            limit_flag <= 1'b0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(push_len);
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + push_len - CNT_W'(pop);
            if (limit_signal)
                limit_flag <= 1'b1;
        end
    end

    // multi-byte write into the first push_len slots
    always_ff @(posedge clk) begin
        if (prefetched_do) begin
            for (int j = 0; j < `PF_BANKS; j++) begin
                if (CNT_W'(j) < push_len)
                    mem[PTR_W'(wr_ptr + j)] <= ordered[j];
            end
        end
    end

    // space_ok is sampled one cycle before the push lands
    a_no_overflow: assert property (@(posedge clk) disable iff (pr_reset)
        prefetched_do |-> (int'(count) + int'(prefetched_length) <= `PF_FIFO_DEPTH))
        else $error("prefetch_fifo: push of %0d with %0d queued", prefetched_length, count);

    // limit_signal only follows the last completion, so no bytes arrive after it
    a_no_push_after_limit: assert property (@(posedge clk) disable iff (pr_reset)
        limit_flag |-> !prefetched_do)
        else $error("prefetch_fifo: push of %0d bytes after the limit", prefetched_length);

endmodule

`default_nettype wire

/* src/prefetch_pkg.sv */
// descriptor layout follows the 8-byte x86 segment descriptor, only base, limit and g are decoded
`default_nettype none

`include "prefetch_config.svh"

package prefetch_pkg;

    // 32-bit linear fetch address, base + eip
    typedef logic [31:0] linear_t;

    // bytes still allowed before the segment limit
    typedef logic [31:0] limit_t;

    // bytes in one fetch, 0 up to PF_BANKS
    typedef logic [$clog2(`PF_BANKS):0] fetch_len_t;

    // row index inside one bank
    typedef logic [$clog2(`PF_BANK_DEPTH)-1:0] bank_addr_t;

    // granularity bit in the cached descriptor
    // set means the 20-bit limit counts 4 KB pages
    localparam int DESC_BIT_G = 55;

endpackage

`default_nettype wire

/* test/tb_code_prefetch.sv */
// memory model covers 1 KB only, higher linear addresses alias on the low 10 bits
`timescale 1ns/1ps
`default_nettype none

module tb_code_prefetch;

    localparam int CLK_HALF    = 4;                        // 8 ns period
    localparam int TOTAL_BYTES = 26 + 300 + 0 + 124 + 20 + 71;
    localparam int SETUP_CYC   = 1024 + 400;               // load, reset and gaps between tests
    localparam int TIMEOUT_NS  = (TOTAL_BYTES * 20 + SETUP_CYC) * 2 * CLK_HALF;

    logic        clk;
    logic        pr_reset;
    logic        flush;
    logic [31:0] prefetch_eip;
    logic [63:0] cs_cache;
    logic        mem_we;
    logic [9:0]  mem_waddr;
    logic [7:0]  mem_wdata;
    logic        code_accept;
    logic        code_valid;
    logic [7:0]  code_byte;
    logic        code_limit;

    integer      seed = 32'h8d614d54;
    string       test_name = "reset";
    logic [1:0]  accept_mode;           // 0 off, 1 always, 2 random
    logic        take;                  // pop seen at the coming edge
    logic [7:0]  mem_model [1024];
    logic [31:0] next_addr;             // model values loaded with the flush
    logic [31:0] next_count;
    logic [31:0] exp_addr;              // next linear address to arrive
    logic [31:0] exp_remaining;         // bytes still owed before the limit
    logic [7:0]  exp_byte;
    int          accepted_cnt;
    int          idle_cnt;              // cycles since the model ran out

    code_prefetch_top uut (
        .clk, .pr_reset, .flush, .prefetch_eip, .cs_cache,
        .mem_we, .mem_waddr, .mem_wdata, .code_accept,
        .code_valid, .code_byte, .code_limit
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    assign exp_byte = mem_model[exp_addr[9:0]];

    // consumer side, decided on the falling edge
    always @(negedge clk) begin
        case (accept_mode)
            2'd1:    code_accept = 1'b1;
            2'd2:    code_accept = (($random(seed) & 32'h3) != 0);   // about 3 in 4
            default: code_accept = 1'b0;
        endcase
        take = code_valid && code_accept;
    end

    // reference model, bytes in address order from base + eip
    always @(posedge clk) begin
        if (pr_reset) begin
            exp_addr      <= 32'd0;
            exp_remaining <= 32'd0;     // nothing owed before the first flush
        end else if (flush) begin
            exp_addr      <= next_addr;
            exp_remaining <= next_count;
        end else if (take) begin
            exp_addr      <= exp_addr + 32'd1;
            exp_remaining <= exp_remaining - 32'd1;
            accepted_cnt  <= accepted_cnt + 1;
        end
        if (pr_reset || flush || exp_remaining != 32'd0)
            idle_cnt <= 0;
        else if (idle_cnt < 7)
            idle_cnt <= idle_cnt + 1;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    a_byte_order: assert property (@(posedge clk) disable iff (pr_reset)
        (code_valid && code_accept) |-> (code_byte == exp_byte))
        else fail_run($sformatf("mismatch %s: expected byte %02h, actual %02h",
                                test_name, $sampled(exp_byte), $sampled(code_byte)));

    a_no_extra_byte: assert property (@(posedge clk) disable iff (pr_reset)
        code_valid |-> (exp_remaining != 32'd0))
        else fail_run($sformatf("mismatch %s: expected code_valid 0, actual 1", test_name));

    a_limit_early: assert property (@(posedge clk) disable iff (pr_reset)
        code_limit |-> (exp_remaining == 32'd0))
        else fail_run($sformatf("mismatch %s: expected code_limit 0, actual 1", test_name));

    // flag needs limit_signal plus one edge, then the queue must be empty
    a_limit_reached: assert property (@(posedge clk) disable iff (pr_reset)
        (idle_cnt >= 3) |-> code_limit)
        else fail_run($sformatf("mismatch %s: expected code_limit 1, actual 0", test_name));

    // x86 layout, base split 63:56 and 39:16, limit split 51:48 and 15:0
    function automatic logic [63:0] make_desc(input logic [31:0] base,
                                              input logic [19:0] lim20, input logic g);
        logic [63:0] d;
        d        = 64'd0;
        d[63:56] = base[31:24];
        d[39:16] = base[23:0];
        d[51:48] = lim20[19:16];
        d[15:0]  = lim20[15:0];
        d[55]    = g;
        return d;
    endfunction

    task automatic load_memory();
        for (int i = 0; i < 1024; i++) begin
            @(negedge clk);
            mem_we       = 1'b1;
            mem_waddr    = i[9:0];
            mem_wdata    = $random(seed);
            mem_model[i] = mem_wdata;
        end
        @(negedge clk);
        mem_we = 1'b0;
    endtask

    task automatic start_stream(input string name, input logic [31:0] base,
                                input logic [19:0] lim20, input logic g,
                                input logic [31:0] eip);
        logic [31:0] lim;
        lim = g ? {lim20, 12'hfff} : {12'd0, lim20};   // page granular limit
        @(negedge clk);
        test_name    = name;
        next_addr    = base + eip;
        next_count   = (lim >= eip) ? lim - eip + 32'd1 : 32'd0;
        prefetch_eip = eip;
        cs_cache     = make_desc(base, lim20, g);
        flush        = 1'b1;
        @(negedge clk);
        flush = 1'b0;
    endtask

    // mode changes on the rising edge, away from the negedge driver
    task automatic set_accept(input logic [1:0] mode);
        @(posedge clk);
        accept_mode = mode;
    endtask

    task automatic wait_accepted(input int n);
        int target;
        target = accepted_cnt + n;
        while (accepted_cnt < target)
            @(negedge clk);
    endtask

    task automatic wait_drained();
        while (exp_remaining != 32'd0)
            @(negedge clk);
        repeat (6) @(negedge clk);      // lets a_limit_reached fire
    endtask

    initial begin
        pr_reset     = 1'b1;
        flush        = 1'b0;
        prefetch_eip = 32'd0;
        cs_cache     = 64'd0;
        mem_we       = 1'b0;
        mem_waddr    = 10'd0;
        mem_wdata    = 8'd0;
        code_accept  = 1'b0;
        accept_mode  = 2'd0;
        take         = 1'b0;
        accepted_cnt = 0;
        next_addr    = 32'd0;
        next_count   = 32'd0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        pr_reset = 1'b0;

        load_memory();                  // code_limit held high meanwhile, no flush yet

        set_accept(2'd1);
        start_stream("small_unaligned", 32'h0000_0100, 20'h0003c, 1'b0, 32'h23);
        wait_drained();

        start_stream("granular_wrap", 32'h0002_0300, 20'h00001, 1'b1, 32'h0b5);
        wait_accepted(300);             // crosses 0x3ff into 0x000

        start_stream("eip_past_limit", 32'h0000_0040, 20'h00010, 1'b0, 32'h11);
        wait_drained();

        set_accept(2'd2);
        start_stream("random_accept", 32'h0000_0208, 20'h00080, 1'b0, 32'h05);
        wait_drained();

        start_stream("flush_mid", 32'h0000_0000, 20'hfffff, 1'b0, 32'h3e1);
        wait_accepted(20);
        set_accept(2'd0);
        repeat (8) @(negedge clk);      // queue fills up
        start_stream("flush_target", 32'h0000_0010, 20'h00060, 1'b0, 32'h1a);
        set_accept(2'd1);
        wait_drained();

        repeat (4) @(negedge clk);
        $display("TEST PASS");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: expected bytes did not all arrive in time");
        $display("TEST FAIL");
        $fatal(1);
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+src
src/prefetch_pkg.sv
src/prefetch.sv
src/code_fetch.sv
src/code_bank.sv
src/prefetch_fifo.sv
src/code_prefetch_top.sv
test/tb_code_prefetch.sv
